/* include/mc_msg_fields.svh */
`ifndef MC_MSG_FIELDS_SVH
`define MC_MSG_FIELDS_SVH

// header field widths, msb first
`define MC_MSG_TYPE_W     8
`define MC_MSHR_ID_W      8
`define MC_PAYLOAD_LEN_W  8
`define MC_HDR_RSVD_W     40

// message type codes
`define MC_MSG_LOAD_MEM_CODE       8'd19
`define MC_MSG_STORE_MEM_CODE      8'd20
`define MC_MSG_LOAD_MEM_ACK_CODE   8'd24
`define MC_MSG_STORE_MEM_ACK_CODE  8'd25

`endif

/* logic/mc_pkg.sv */
`include "mc_msg_fields.svh"

package mc_pkg;

  localparam int NOC_DATA_WIDTH = 64;  // flit width
  localparam int MEM_ADDR_WIDTH = 64;  // byte address
  localparam int WORD_BYTES     = 8;   // bytes per memory word

  typedef enum logic [`MC_MSG_TYPE_W-1:0] {
    MSG_LOAD_MEM      = `MC_MSG_LOAD_MEM_CODE,
    MSG_STORE_MEM     = `MC_MSG_STORE_MEM_CODE,
    MSG_LOAD_MEM_ACK  = `MC_MSG_LOAD_MEM_ACK_CODE,
    MSG_STORE_MEM_ACK = `MC_MSG_STORE_MEM_ACK_CODE
  } msg_type_e;

  typedef struct packed {
    msg_type_e                     msg_type;
    logic [`MC_MSHR_ID_W-1:0]      mshr_id;      // requester tag, echoed back
    logic [`MC_PAYLOAD_LEN_W-1:0]  payload_len;  // flits after the header
    logic [`MC_HDR_RSVD_W-1:0]     reserved;
  } flit_hdr_t;

  typedef struct packed {
    logic                       is_store;
    logic [MEM_ADDR_WIDTH-1:0]  addr;
    logic [NOC_DATA_WIDTH-1:0]  wdata;
    logic                       spare;  // tied low
  } mem_req_t;

  typedef struct packed {
    logic [NOC_DATA_WIDTH-1:0]  rdata;
    logic                       was_store;
  } mem_rsp_t;

endpackage

/* logic/mc_reset_seq.sv */
`timescale 1ns/1ns

module mc_reset_seq #(
  parameter int RESET_DELAY = 32
) (
  input  logic core_ref_clk,
  input  logic sys_rst_n,
  output logic user_rst,
  output logic calib_done
);

  localparam int CNT_W = $clog2(RESET_DELAY + 1);

  logic [CNT_W-1:0] delay_cnt;

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      delay_cnt <= CNT_W'(RESET_DELAY);
    end else if (delay_cnt != '0) begin
      delay_cnt <= delay_cnt - 1'b1;  // stops at zero
    end
  end

  // user side reset held while the delay runs
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      user_rst <= 1'b1;
    end else begin
      user_rst <= (delay_cnt != '0);
    end
  end

  // no real calibration here, done one cycle after user reset drops
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      calib_done <= 1'b0;
    end else begin
      calib_done <= ~user_rst;
    end
  end

endmodule

/* logic/noc_mem_bridge.sv */
`timescale 1ns/1ns

module noc_mem_bridge
  import mc_pkg::*;
(
  input  logic                      core_ref_clk,
  input  logic                      user_rst,
  input  logic                      calib_done,
  input  logic [NOC_DATA_WIDTH-1:0] flit_in_data,
  input  logic                      flit_in_val,
  output logic                      flit_in_rdy,
  output logic [NOC_DATA_WIDTH-1:0] flit_out_data,
  output logic                      flit_out_val,
  input  logic                      flit_out_rdy,
  output mem_req_t                  mem_req,
  output logic                      mem_req_val,
  input  mem_rsp_t                  mem_rsp,
  input  logic                      mem_rsp_val
);

  typedef enum logic [2:0] {
    RECV_HDR,
    RECV_ADDR,
    RECV_DATA,
    DROP_PAYLOAD,
    ISSUE,
    WAIT_MEM,
    SEND_HDR,
    SEND_DATA
  } bridge_state_e;

  bridge_state_e             state;
  flit_hdr_t                 in_hdr;
  flit_hdr_t                 hdr_q;
  flit_hdr_t                 rsp_hdr;
  logic [MEM_ADDR_WIDTH-1:0] addr_q;
  logic [NOC_DATA_WIDTH-1:0] wdata_q;
  logic [NOC_DATA_WIDTH-1:0] rdata_q;
  logic                      rsp_store_q;
  logic [7:0]                drop_cnt;
  logic                      in_fire;
  logic                      out_fire;

  assign in_hdr   = flit_hdr_t'(flit_in_data);
  assign in_fire  = flit_in_val & flit_in_rdy;
  assign out_fire = flit_out_val & flit_out_rdy;

  // only listen while collecting a request
  assign flit_in_rdy = calib_done &
                       ((state == RECV_HDR) || (state == RECV_ADDR) ||
                        (state == RECV_DATA) || (state == DROP_PAYLOAD));

  always_ff @(posedge core_ref_clk) begin
    if (user_rst) begin
      state    <= RECV_HDR;
      drop_cnt <= '0;
    end else begin
      unique case (state)
        RECV_HDR: begin
          if (in_fire) begin
            if (in_hdr.msg_type == MSG_LOAD_MEM || in_hdr.msg_type == MSG_STORE_MEM) begin
              state <= RECV_ADDR;
            end else if (in_hdr.payload_len != '0) begin
              state    <= DROP_PAYLOAD;  // unknown type, swallow its payload
              drop_cnt <= in_hdr.payload_len;
            end
          end
        end
        RECV_ADDR: begin
          if (in_fire) begin
            state <= (hdr_q.msg_type == MSG_STORE_MEM) ? RECV_DATA : ISSUE;
          end
        end
        RECV_DATA: begin
          if (in_fire) begin
            state <= ISSUE;
          end
        end
        DROP_PAYLOAD: begin
          if (in_fire) begin
            drop_cnt <= drop_cnt - 1'b1;
            if (drop_cnt == 8'd1) begin
              state <= RECV_HDR;
            end
          end
        end
        ISSUE: state <= WAIT_MEM;  // single-cycle request strobe
        WAIT_MEM: begin
          if (mem_rsp_val) begin
            state <= SEND_HDR;
          end
        end
        SEND_HDR: begin
          if (out_fire) begin
            state <= rsp_store_q ? RECV_HDR : SEND_DATA;
          end
        end
        SEND_DATA: begin
          if (out_fire) begin
            state <= RECV_HDR;
          end
        end
        default: state <= RECV_HDR;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge core_ref_clk) begin
    if (state == RECV_HDR && in_fire) begin
      hdr_q <= in_hdr;
    end
    if (state == RECV_ADDR && in_fire) begin
      addr_q <= flit_in_data;
    end
    if (state == RECV_DATA && in_fire) begin
      wdata_q <= flit_in_data;
    end
    if (state == WAIT_MEM && mem_rsp_val) begin
      rdata_q     <= mem_rsp.rdata;
      rsp_store_q <= mem_rsp.was_store;
    end
  end

  assign mem_req_val    = (state == ISSUE);
  assign mem_req.is_store = (hdr_q.msg_type == MSG_STORE_MEM);
  assign mem_req.addr   = addr_q;
  assign mem_req.wdata  = wdata_q;
  assign mem_req.spare  = 1'b0;

  // response header, tag echoed from the request
  always_comb begin
    rsp_hdr.msg_type    = rsp_store_q ? MSG_STORE_MEM_ACK : MSG_LOAD_MEM_ACK;
    rsp_hdr.mshr_id     = hdr_q.mshr_id;
    rsp_hdr.payload_len = rsp_store_q ? 8'd0 : 8'd1;
    rsp_hdr.reserved    = '0;
  end

  assign flit_out_val  = (state == SEND_HDR) || (state == SEND_DATA);
  assign flit_out_data = (state == SEND_HDR) ? NOC_DATA_WIDTH'(rsp_hdr) : rdata_q;

endmodule

/* logic/behav_mem.sv */
`timescale 1ns/1ns

module behav_mem
  import mc_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic     core_ref_clk,
  input  mem_req_t mem_req,
  input  logic     mem_req_val,
  output mem_rsp_t mem_rsp,
  output logic     mem_rsp_val
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int OFS_W = $clog2(WORD_BYTES);

  logic [NOC_DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]          word_idx;

  // upper address bits fold onto the array
  assign word_idx = mem_req.addr[OFS_W +: IDX_W];

  always_ff @(posedge core_ref_clk) begin
    if (mem_req_val && mem_req.is_store) begin
      mem[word_idx] <= mem_req.wdata;
    end
  end

  // read old contents on every access, store too
  always_ff @(posedge core_ref_clk) begin
    if (mem_req_val) begin
      mem_rsp.rdata     <= mem[word_idx];
      mem_rsp.was_store <= mem_req.is_store;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    mem_rsp_val <= mem_req_val;  // fixed one-cycle latency
  end

endmodule

/* logic/mc_top.sv */
`timescale 1ns/1ns

module mc_top
  import mc_pkg::*;
#(
  parameter int RESET_DELAY = 32,
  parameter int MEM_WORDS   = 256
) (
  input  logic                      core_ref_clk,
  input  logic                      sys_rst_n,
  input  logic [NOC_DATA_WIDTH-1:0] mc_flit_in_data,
  input  logic                      mc_flit_in_val,
  output logic                      mc_flit_in_rdy,
  output logic [NOC_DATA_WIDTH-1:0] mc_flit_out_data,
  output logic                      mc_flit_out_val,
  input  logic                      mc_flit_out_rdy,
  output logic                      mc_ui_clk_sync_rst,
  output logic                      init_calib_complete_out
);

  mem_req_t mem_req;
  logic     mem_req_val;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_val;

  mc_reset_seq #(
    .RESET_DELAY (RESET_DELAY)
  ) u_reset_seq (
    .core_ref_clk (core_ref_clk),
    .sys_rst_n    (sys_rst_n),
    .user_rst     (mc_ui_clk_sync_rst),
    .calib_done   (init_calib_complete_out)
  );

  noc_mem_bridge u_bridge (
    .core_ref_clk  (core_ref_clk),
    .user_rst      (mc_ui_clk_sync_rst),
    .calib_done    (init_calib_complete_out),
    .flit_in_data  (mc_flit_in_data),
    .flit_in_val   (mc_flit_in_val),
    .flit_in_rdy   (mc_flit_in_rdy),
    .flit_out_data (mc_flit_out_data),
    .flit_out_val  (mc_flit_out_val),
    .flit_out_rdy  (mc_flit_out_rdy),
    .mem_req       (mem_req),
    .mem_req_val   (mem_req_val),
    .mem_rsp       (mem_rsp),
    .mem_rsp_val   (mem_rsp_val)
  );

  // stands in for the DDR controller
  behav_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .core_ref_clk (core_ref_clk),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_rsp      (mem_rsp),
    .mem_rsp_val  (mem_rsp_val)
  );

endmodule

/* sim/mc_top_properties.sv */
`timescale 1ns/1ns

module mc_top_properties (
  input logic        core_ref_clk,
  input logic        sys_rst_n,
  input logic        mc_flit_in_rdy,
  input logic [63:0] mc_flit_out_data,
  input logic        mc_flit_out_val,
  input logic        mc_flit_out_rdy,
  input logic        mc_ui_clk_sync_rst,
  input logic        init_calib_complete_out
);

  // stalled response flit must not change
  assert property (@(posedge core_ref_clk) disable iff (!sys_rst_n)
    (mc_flit_out_val && !mc_flit_out_rdy) |=> $stable(mc_flit_out_data))
    else $error("response flit changed while stalled");

  assert property (@(posedge core_ref_clk) disable iff (!sys_rst_n)
    !init_calib_complete_out |-> !mc_flit_in_rdy)
    else $error("request port ready before calibration complete");

  assert property (@(posedge core_ref_clk) disable iff (!sys_rst_n)
    mc_ui_clk_sync_rst |-> !mc_flit_out_val)
    else $error("response valid while user reset is active");

endmodule

/* sim/tb_mc_top.sv */
`timescale 1ns/1ns

module tb_mc_top
  import mc_pkg::*;
();

  localparam int RESET_DELAY = 32;
  localparam int MEM_WORDS   = 256;
  localparam int MAX_CYCLES  = 2000;  // ~40 messages of up to 15 cycles plus reset

  logic                      core_ref_clk;
  logic                      sys_rst_n;
  logic [NOC_DATA_WIDTH-1:0] mc_flit_in_data;
  logic                      mc_flit_in_val;
  logic                      mc_flit_in_rdy;
  logic [NOC_DATA_WIDTH-1:0] mc_flit_out_data;
  logic                      mc_flit_out_val;
  logic                      mc_flit_out_rdy;
  logic                      mc_ui_clk_sync_rst;
  logic                      init_calib_complete_out;
  logic [NOC_DATA_WIDTH-1:0] ref_mem [MEM_WORDS];  // expected memory contents
  int                        errors;
  int                        cycle_cnt;
  integer                    seed;

  mc_top #(
    .RESET_DELAY (RESET_DELAY),
    .MEM_WORDS   (MEM_WORDS)
  ) uut (
    .core_ref_clk            (core_ref_clk),
    .sys_rst_n               (sys_rst_n),
    .mc_flit_in_data         (mc_flit_in_data),
    .mc_flit_in_val          (mc_flit_in_val),
    .mc_flit_in_rdy          (mc_flit_in_rdy),
    .mc_flit_out_data        (mc_flit_out_data),
    .mc_flit_out_val         (mc_flit_out_val),
    .mc_flit_out_rdy         (mc_flit_out_rdy),
    .mc_ui_clk_sync_rst      (mc_ui_clk_sync_rst),
    .init_calib_complete_out (init_calib_complete_out)
  );

  bind mc_top mc_top_properties props (
    .core_ref_clk            (core_ref_clk),
    .sys_rst_n               (sys_rst_n),
    .mc_flit_in_rdy          (mc_flit_in_rdy),
    .mc_flit_out_data        (mc_flit_out_data),
    .mc_flit_out_val         (mc_flit_out_val),
    .mc_flit_out_rdy         (mc_flit_out_rdy),
    .mc_ui_clk_sync_rst      (mc_ui_clk_sync_rst),
    .init_calib_complete_out (init_calib_complete_out)
  );

  always #50 core_ref_clk = ~core_ref_clk;

  always @(posedge core_ref_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] make_hdr(input logic [7:0] t, input logic [7:0] id,
                                           input logic [7:0] len);
    make_hdr = {t, id, len, 40'h0};  // type, tag, length, reserved
  endfunction

  function automatic int word_index(input logic [63:0] addr);
    return int'((addr / WORD_BYTES) % MEM_WORDS);
  endfunction

  function automatic logic [63:0] rand_word();
    rand_word = {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] rand_addr();
    rand_addr = rand_word() & ~64'h7;  // word aligned
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // starts right after a rising edge and returns right after the transfer edge
  task automatic send_flit(input logic [63:0] d);
    mc_flit_in_data <= d;
    mc_flit_in_val  <= 1'b1;
    @(negedge core_ref_clk);
    while (!mc_flit_in_rdy) @(negedge core_ref_clk);
    @(posedge core_ref_clk);
    mc_flit_in_val <= 1'b0;
  endtask

  task automatic recv_flit(output logic [63:0] d);
    @(negedge core_ref_clk);
    while (!mc_flit_out_val) @(negedge core_ref_clk);
    d = mc_flit_out_data;
    @(posedge core_ref_clk);  // taken here with rdy high
  endtask

  task automatic do_store(input logic [63:0] addr, input logic [63:0] data,
                          input logic [7:0] id);
    logic [63:0] flit;
    send_flit(make_hdr(MSG_STORE_MEM, id, 8'd2));
    send_flit(addr);
    send_flit(data);
    recv_flit(flit);
    check_val(flit, make_hdr(MSG_STORE_MEM_ACK, id, 8'd0), "store ack header");
    ref_mem[word_index(addr)] = data;
  endtask

  task automatic do_load(input logic [63:0] addr, input logic [7:0] id);
    logic [63:0] flit;
    send_flit(make_hdr(MSG_LOAD_MEM, id, 8'd1));
    send_flit(addr);
    recv_flit(flit);
    check_val(flit, make_hdr(MSG_LOAD_MEM_ACK, id, 8'd1), "load ack header");
    recv_flit(flit);
    check_val(flit, ref_mem[word_index(addr)], "load data");
  endtask

  task automatic test_reset();
    int n;
    repeat (2) @(posedge core_ref_clk);
    @(negedge core_ref_clk);
    if (!mc_ui_clk_sync_rst || init_calib_complete_out || mc_flit_out_val || mc_flit_in_rdy) begin
      errors++;
      $display("Mismatch at %0t: reset outputs not in their reset state during reset", $time);
    end
    @(posedge core_ref_clk);
    sys_rst_n <= 1'b1;
    @(posedge core_ref_clk);  // first edge with reset released
    @(negedge core_ref_clk);
    if (!mc_ui_clk_sync_rst || init_calib_complete_out || mc_flit_out_val || mc_flit_in_rdy) begin
      errors++;
      $display("Mismatch at %0t: reset outputs not in their reset state just after reset",
               $time);
    end
    n = 0;
    while (!init_calib_complete_out && n < 100) begin
      @(posedge core_ref_clk);
      n++;
      @(negedge core_ref_clk);
    end
    check_val(64'(n), 64'(RESET_DELAY + 1), "cycles to calibration complete");
    if (!mc_flit_in_rdy) begin
      errors++;
      $display("Mismatch at %0t: request port not ready after calibration complete", $time);
    end
    @(posedge core_ref_clk);
  endtask

  task automatic test_store_load();
    logic [63:0] addrs [6];
    for (int i = 0; i < 6; i++) begin
      addrs[i] = rand_addr();
      do_store(addrs[i], rand_word(), 8'(i));
    end
    for (int i = 0; i < 6; i++) begin
      do_load(addrs[i], 8'(8'h10 + i));
    end
  endtask

  task automatic test_overwrite();
    logic [63:0] addr;
    addr = rand_addr();
    do_store(addr, rand_word(), 8'h20);
    do_store(addr, rand_word(), 8'h21);  // second store wins
    do_load(addr, 8'h22);
  endtask

  task automatic test_wrap();
    logic [63:0] addr;
    addr = rand_addr() & 64'h7f8;
    do_store(addr + MEM_WORDS * WORD_BYTES, rand_word(), 8'h30);
    do_load(addr, 8'h31);
  endtask

  task automatic test_backpressure();
    logic [63:0] addr;
    logic [63:0] flit;
    addr = rand_addr();
    do_store(addr, rand_word(), 8'h40);
    mc_flit_out_rdy <= 1'b0;
    send_flit(make_hdr(MSG_LOAD_MEM, 8'h41, 8'd1));
    send_flit(addr);
    @(negedge core_ref_clk);
    while (!mc_flit_out_val) @(negedge core_ref_clk);
    for (int i = 0; i < 5; i++) begin
      check_val(mc_flit_out_data, make_hdr(MSG_LOAD_MEM_ACK, 8'h41, 8'd1), "held header");
      if (!mc_flit_out_val || mc_flit_in_rdy) begin
        errors++;
        $display("Mismatch at %0t: handshake state wrong while response is stalled", $time);
      end
      @(negedge core_ref_clk);
    end
    @(posedge core_ref_clk);
    mc_flit_out_rdy <= 1'b1;
    recv_flit(flit);
    check_val(flit, make_hdr(MSG_LOAD_MEM_ACK, 8'h41, 8'd1), "header after stall");
    recv_flit(flit);
    check_val(flit, ref_mem[word_index(addr)], "data after stall");
  endtask

  task automatic test_unknown();
    logic [63:0] addr;
    addr = rand_addr();
    do_store(addr, rand_word(), 8'h50);
    send_flit(make_hdr(8'ha5, 8'h51, 8'd2));  // undefined type
    send_flit(rand_word());
    send_flit(rand_word());
    for (int i = 0; i < 8; i++) begin
      @(negedge core_ref_clk);
      if (mc_flit_out_val) begin
        errors++;
        $display("response sent for a message of unknown type");
      end
    end
    @(posedge core_ref_clk);
    do_load(addr, 8'h52);
  endtask

  initial begin
    core_ref_clk    = 1'b0;
    sys_rst_n       = 1'b0;
    mc_flit_in_data = '0;
    mc_flit_in_val  = 1'b0;
    mc_flit_out_rdy = 1'b1;
    errors          = 0;
    cycle_cnt       = 0;
    seed            = 32'h292d;
    test_reset();
    test_store_load();
    test_overwrite();
    test_wrap();
    test_backpressure();
    test_unknown();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
logic/mc_pkg.sv
logic/mc_reset_seq.sv
logic/noc_mem_bridge.sv
logic/behav_mem.sv
logic/mc_top.sv
sim/mc_top_properties.sv
sim/tb_mc_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mc_top -f list.f || exit 1
out="$(./obj_dir/Vtb_mc_top)"
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$" && exit 0 || exit 1
